// File: filelist.f
verilog/udp_ctrl_pkg.sv
verilog/reset_sequencer.sv
verilog/local_address_ctrl.sv
verilog/frame_counter_bank.sv
verilog/debug_wb_regs.sv
verilog/udp_ctrl_top.sv
testbench/tb_udp_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --timescale 1ns/1ns -f filelist.f \
    --top-module tb_udp_ctrl -Mdir "$build_dir" -o tb_udp_ctrl
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/tb_udp_ctrl" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "TEST FAILED" "$log_file"; then
    exit 1
fi
if ! grep -q "TEST PASSED" "$log_file"; then
    echo "no pass line found in $log_file"
    exit 1
fi
exit 0

// File: testbench/tb_udp_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_udp_ctrl;
    import udp_ctrl_pkg::*;

    localparam int reset_cycles    = 16;
    localparam int interval        = 201;   // host index step period
    localparam int stack_cycles    = 255;
    localparam int phy_cycles      = 128;
    localparam int ack_limit       = 16;
    localparam int watchdog_cycles = 16 + 300 + 20 * 201 + 2000;
    localparam logic [47:0] unicast_exp = 48'hac89_6745_2301;   // mac bytes reversed
    localparam frame_strobes_t fifo_idle = '{app_rx: 1'b0, app_tx: 1'b0, fifo_rx: 1'b1,
                                             fifo_tx: 1'b1, mac_rx: 1'b0, mac_tx: 1'b0};

    logic           temac_clk;
    logic           key1;
    frame_strobes_t strobes;
    wb_req_t        wb_i;
    wb_rsp_t        wb_o;
    logic           stack_reset;
    logic           phy_reset_n;
    local_addr_t    local_addr;

    int             rel_cycle = 0;          // clock edges since key1 release
    integer         seed = 32'hc47cb446;
    int             count_errors = 0;
    int             addr_errors = 0;
    int             flag_errors = 0;
    int             proto_errors = 0;
    frame_counts_t  exp_counts;

    udp_ctrl_top i_dut (
        .temac_clk   (temac_clk  ),
        .key1        (key1       ),
        .strobes     (strobes    ),
        .wb_i        (wb_i       ),
        .wb_o        (wb_o       ),
        .stack_reset (stack_reset),
        .phy_reset_n (phy_reset_n),
        .local_addr  (local_addr )
    );

    initial
    begin
        temac_clk = 1'b0;
        forever #20 temac_clk = ~temac_clk;
    end

    always @(posedge temac_clk)
    begin
        if (key1)
            rel_cycle <= rel_cycle + 1;
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge temac_clk);
        $display("watchdog ran out after %0d cycles, the tests did not finish", watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_count(input logic [data_w-1:0] got, input logic [data_w-1:0] want,
                               input string what);
        if (got !== want)
        begin
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, want);
            count_errors++;
        end
    endtask

    task automatic check_addr(input local_addr_t got, input local_addr_t want);
        if (got !== want)
        begin
            $display("ERROR %0t: local_addr is %h, expected %h", $time, got, want);
            addr_errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        if (got !== want)
        begin
            $display("ERROR %0t: %s is %b, expected %b", $time, what, got, want);
            flag_errors++;
        end
    endtask

    // --------------------------------------------------
    // expected address state after edge k
    // --------------------------------------------------
    function automatic logic [31:0] expected_ip(input int k);
        int steps;
        steps = k / interval;
        if (steps < 2)
            return local_ip_default;   // first step falls inside stack reset
        return {local_ip_default[31:8], 8'((steps - 1) % 16)};
    endfunction

    function automatic local_addr_t expected_addr(input int k);
        local_addr_t a;
        logic [31:0] prev_ip;
        prev_ip      = expected_ip(k - 1);
        a.ip         = expected_ip(k);
        a.ip_valid   = (k > stack_cycles);
        a.port       = (k > stack_cycles) ? {12'd0, prev_ip[3:0]} + 16'd3 : local_port_default;
        a.port_valid = (k > stack_cycles);
        a.unicast    = unicast_exp;
        return a;
    endfunction

    task automatic wait_until(input int k);
        while (rel_cycle < k)
            @(negedge temac_clk);
        if (rel_cycle != k)
        begin
            $display("missed the check at cycle %0d, already at cycle %0d", k, rel_cycle);
            proto_errors++;
        end
    endtask

    // --------------------------------------------------
    // wishbone master
    // --------------------------------------------------
    task automatic wb_access(input logic [adr_w-1:0] adr, input logic we,
                             input logic [data_w-1:0] wdat,
                             output logic [data_w-1:0] rdat, output int sample_k);
        int waited;
        waited = 0;
        @(posedge temac_clk);
        wb_i <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        @(negedge temac_clk);
        sample_k = rel_cycle;                 // state the slave samples
        check_flag(wb_o.ack, 1'b0, "early ack");
        @(negedge temac_clk);
        while (!wb_o.ack && waited < ack_limit)
        begin
            @(negedge temac_clk);
            waited++;
        end
        if (!wb_o.ack)
        begin
            $display("no ack for the wishbone access to address %0d", adr);
            proto_errors++;
        end
        rdat = wb_o.dat;
        @(posedge temac_clk);
        wb_i <= '0;
        @(negedge temac_clk);
        check_flag(wb_o.ack, 1'b0, "ack after the pulse");
    endtask

    task automatic wb_read(input logic [adr_w-1:0] adr, output logic [data_w-1:0] rdat,
                           output int sample_k);
        wb_access(adr, 1'b0, '0, rdat, sample_k);
    endtask

    task automatic wb_write(input logic [adr_w-1:0] adr, input logic [data_w-1:0] wdat);
        logic [data_w-1:0] unused;
        int                k;
        wb_access(adr, 1'b1, wdat, unused, k);
    endtask

    task automatic check_all_counts(input frame_counts_t want);
        logic [data_w-1:0] rdat;
        int                k;
        wb_read(reg_app_rx, rdat, k);
        check_count(rdat, want.app_rx, "app_rx count");
        wb_read(reg_app_tx, rdat, k);
        check_count(rdat, want.app_tx, "app_tx count");
        wb_read(reg_fifo_rx, rdat, k);
        check_count(rdat, want.fifo_rx, "fifo_rx count");
        wb_read(reg_fifo_tx, rdat, k);
        check_count(rdat, want.fifo_tx, "fifo_tx count");
        wb_read(reg_mac_rx, rdat, k);
        check_count(rdat, want.mac_rx, "mac_rx count");
        wb_read(reg_mac_tx, rdat, k);
        check_count(rdat, want.mac_tx, "mac_tx count");
    endtask

    task automatic pulse_strobe(input frame_strobes_t sel, input int count, input int width);
        int gap;
        for (int n = 0; n < count; n++)
        begin
            @(posedge temac_clk);
            strobes <= sel ^ fifo_idle;       // fifo fields pulse low
            repeat (width) @(posedge temac_clk);
            strobes <= fifo_idle;
            gap = 1 + {$random(seed)} % 4;
            repeat (gap - 1) @(posedge temac_clk);
        end
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic test_reset_sequence();
        for (int i = 0; i < reset_cycles - 1; i++)
        begin
            @(negedge temac_clk);
            check_flag(stack_reset, 1'b1, "stack_reset in reset");
            check_flag(phy_reset_n, 1'b0, "phy_reset_n in reset");
            check_flag(wb_o.ack, 1'b0, "ack in reset");
            check_addr(local_addr, expected_addr(0));
        end
        @(posedge temac_clk);
        key1 <= 1'b1;
        for (int k = 1; k <= stack_cycles + 5; k++)
        begin
            wait_until(k);
            check_flag(stack_reset, k < stack_cycles, "stack_reset after release");
            check_flag(phy_reset_n, k >= phy_cycles, "phy_reset_n after release");
            check_addr(local_addr, expected_addr(k));
        end
        exp_counts = '0;
        check_all_counts(exp_counts);
    endtask

    task automatic test_address_stepping();
        logic [data_w-1:0] rdat;
        local_addr_t       want;
        int                k;
        for (int m = 2; m <= 18; m++)       // runs past the host index wrap
        begin
            wait_until(interval * m + 3);
            check_addr(local_addr, expected_addr(rel_cycle));
            check_flag(local_addr.ip_valid, 1'b1, "ip_valid");
            check_flag(local_addr.port_valid, 1'b1, "port_valid");
            wb_read(reg_local_ip, rdat, k);
            check_count(rdat, expected_ip(k), "local ip register");
            wb_read(reg_local_port, rdat, k);
            want = expected_addr(k);
            check_count(rdat, {14'd0, want.ip_valid, want.port_valid, want.port},
                        "local port register");
        end
    endtask

    task automatic test_unicast_address();
        logic [data_w-1:0] lo;
        logic [data_w-1:0] hi;
        int                k;
        wb_read(reg_unicast_lo, lo, k);
        wb_read(reg_unicast_hi, hi, k);
        check_count(lo, unicast_exp[31:0], "unicast low word");
        check_count(hi, {16'd0, unicast_exp[47:32]}, "unicast high word");
    endtask

    task automatic test_frame_counting();
        pulse_strobe('{app_rx: 1'b1, default: 1'b0}, 3, 1);
        pulse_strobe('{app_tx: 1'b1, default: 1'b0}, 5, 2);
        pulse_strobe('{fifo_rx: 1'b1, default: 1'b0}, 2, 1);
        pulse_strobe('{fifo_tx: 1'b1, default: 1'b0}, 4, 1);
        pulse_strobe('{mac_rx: 1'b1, default: 1'b0}, 1, 5);   // long pulse counts once
        pulse_strobe('{mac_tx: 1'b1, default: 1'b0}, 6, 1);
        repeat (6) @(posedge temac_clk);
        exp_counts = '{app_rx: 32'd3, app_tx: 32'd5, fifo_rx: 32'd2, fifo_tx: 32'd4,
                       mac_rx: 32'd1, mac_tx: 32'd6};
        check_all_counts(exp_counts);
    endtask

    task automatic test_counter_clear();
        wb_write(reg_mac_tx, 32'hffff_ffff);
        exp_counts.mac_tx = '0;
        check_all_counts(exp_counts);
        pulse_strobe('{mac_tx: 1'b1, default: 1'b0}, 1, 1);
        repeat (6) @(posedge temac_clk);
        exp_counts.mac_tx = 32'd1;
        check_all_counts(exp_counts);
    endtask

    task automatic test_wishbone_protocol();
        logic [data_w-1:0] rdat;
        int                k;
        wb_read(4'hc, rdat, k);
        check_count(rdat, '0, "unmapped read");
        wb_write(4'ha, 32'h1234_5678);
        wb_read(4'ha, rdat, k);
        check_count(rdat, '0, "unmapped read after write");
        wb_write(reg_local_ip, 32'hdead_beef);
        wb_read(reg_local_ip, rdat, k);
        check_count(rdat, expected_ip(k), "local ip after write");
        check_addr(local_addr, expected_addr(rel_cycle));
        check_all_counts(exp_counts);
    endtask

    initial
    begin
        key1    <= 1'b0;
        strobes <= fifo_idle;
        wb_i    <= '0;
        test_reset_sequence();
        test_address_stepping();
        test_unicast_address();
        test_frame_counting();
        test_counter_clear();
        test_wishbone_protocol();
        repeat (4) @(posedge temac_clk);
        $display("errors: count %0d, address %0d, flag %0d, protocol %0d",
                 count_errors, addr_errors, flag_errors, proto_errors);
        if (count_errors + addr_errors + flag_errors + proto_errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/debug_wb_regs.sv
`timescale 1ns/1ns
`default_nettype none

module debug_wb_regs (
    input  logic                         temac_clk,
    input  logic                         key1,
    input  udp_ctrl_pkg::wb_req_t        wb_i,
    output udp_ctrl_pkg::wb_rsp_t        wb_o,
    input  udp_ctrl_pkg::frame_counts_t  counts,
    input  udp_ctrl_pkg::local_addr_t    local_addr,
    output udp_ctrl_pkg::frame_strobes_t clear
);
    import udp_ctrl_pkg::*;

    logic              req;         // new access, not yet acked
    logic              ack_q;
    logic [data_w-1:0] rd_data;
    logic [data_w-1:0] rd_data_q;
    frame_strobes_t    clr_sel;     // one-hot counter select
    frame_strobes_t    clear_q;

    assign req = wb_i.cyc & wb_i.stb & ~ack_q;

    // --------------------------------------------------
    // address decode
    // --------------------------------------------------
    always_comb
    begin
        rd_data = '0;
        clr_sel = '0;
        case (wb_i.adr)
            reg_app_rx:     begin rd_data = counts.app_rx;  clr_sel.app_rx  = 1'b1; end
            reg_app_tx:     begin rd_data = counts.app_tx;  clr_sel.app_tx  = 1'b1; end
            reg_fifo_rx:    begin rd_data = counts.fifo_rx; clr_sel.fifo_rx = 1'b1; end
            reg_fifo_tx:    begin rd_data = counts.fifo_tx; clr_sel.fifo_tx = 1'b1; end
            reg_mac_rx:     begin rd_data = counts.mac_rx;  clr_sel.mac_rx  = 1'b1; end
            reg_mac_tx:     begin rd_data = counts.mac_tx;  clr_sel.mac_tx  = 1'b1; end
            reg_local_ip:   rd_data = local_addr.ip;
            reg_local_port: rd_data = {14'd0, local_addr.ip_valid, local_addr.port_valid,
                                       local_addr.port};
            reg_unicast_lo: rd_data = local_addr.unicast[31:0];
            reg_unicast_hi: rd_data = {16'd0, local_addr.unicast[47:32]};
            default:        rd_data = '0;   // unmapped
        endcase
    end

    // --------------------------------------------------
    // handshake and clear pulses
    // --------------------------------------------------
    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
        begin
            ack_q   <= 1'b0;
            clear_q <= '0;
        end
        else
        begin
            ack_q   <= req;                                   // one cycle pulse
            clear_q <= (req && wb_i.we) ? clr_sel : '0;       // lands in ack cycle
        end
    end

    always_ff @(posedge temac_clk)
    begin
        if (req)
            rd_data_q <= rd_data;
    end

    assign wb_o  = '{ack: ack_q, dat: rd_data_q};
    assign clear = clear_q;

endmodule

`default_nettype wire

// File: verilog/frame_counter_bank.sv
`timescale 1ns/1ns
`default_nettype none

module frame_counter_bank (
    input  logic                         temac_clk,
    input  logic                         key1,
    input  udp_ctrl_pkg::frame_strobes_t strobes,
    input  udp_ctrl_pkg::frame_strobes_t clear,
    output udp_ctrl_pkg::frame_counts_t  counts
);
    import udp_ctrl_pkg::*;

    frame_strobes_t                     strobes_norm;   // all active high
    logic [num_strobes-1:0]             stage0;
    logic [num_strobes-1:0]             stage1;
    logic [num_strobes-1:0]             stage2;
    logic [num_strobes-1:0]             rise_q;         // registered edge pulse
    logic [num_strobes-1:0]             clr;
    logic [num_strobes-1:0][data_w-1:0] cnt;

    // fifo strobes come in active low
    always_comb
    begin
        strobes_norm         = strobes;
        strobes_norm.fifo_rx = ~strobes.fifo_rx;
        strobes_norm.fifo_tx = ~strobes.fifo_tx;
    end

    assign clr = clear;

    // --------------------------------------------------
    // strobe delay pipeline
    // --------------------------------------------------
    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
        begin
            stage0 <= '0;
            stage1 <= '0;
            stage2 <= '0;
            rise_q <= '0;
        end
        else
        begin
            stage0 <= strobes_norm;
            stage1 <= stage0;
            stage2 <= stage1;
            rise_q <= stage1 & ~stage2;   // rising edge between last two stages
        end
    end

    // --------------------------------------------------
    // frame counters
    // --------------------------------------------------
    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
        begin
            cnt <= '0;
        end
        else
        begin
            for (int i = 0; i < num_strobes; i++)
            begin
                if (clr[i])
                    cnt[i] <= '0;                      // clear beats increment
                else if (rise_q[i])
                    cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    assign counts = frame_counts_t'(cnt);

endmodule

`default_nettype wire

// File: verilog/local_address_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module local_address_ctrl (
    input  logic                      temac_clk,
    input  logic                      key1,
    input  logic                      stack_reset,
    output udp_ctrl_pkg::local_addr_t local_addr
);
    import udp_ctrl_pkg::*;

    logic [addr_cnt_w-1:0] interval_cnt;
    logic                  interval_end;
    logic [host_w-1:0]     host_idx;     // current host index
    logic [31:0]           ip_q;
    logic                  ip_valid_q;
    logic [15:0]           port_q;
    logic                  port_valid_q;
    logic [47:0]           unicast;

    // --------------------------------------------------
    // address step timing
    // --------------------------------------------------
    assign interval_end = (interval_cnt == addr_cnt_w'(addr_interval_cycles));

    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
        begin
            interval_cnt <= '0;
            host_idx     <= '0;
        end
        else if (interval_end)
        begin
            interval_cnt <= '0;
            if (host_idx == host_w'(host_last))
                host_idx <= '0;                 // wrap after last host
            else
                host_idx <= host_idx + 1'b1;
        end
        else
        begin
            interval_cnt <= interval_cnt + 1'b1;
        end
    end

    // --------------------------------------------------
    // local ip and port
    // --------------------------------------------------
    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
        begin
            ip_q         <= local_ip_default;
            ip_valid_q   <= 1'b0;
            port_q       <= local_port_default;
            port_valid_q <= 1'b0;
        end
        else if (stack_reset)
        begin
            ip_q         <= local_ip_default;   // hold defaults while stack is down
            ip_valid_q   <= 1'b0;
            port_q       <= local_port_default;
            port_valid_q <= 1'b0;
        end
        else
        begin
            if (interval_end)
                ip_q <= {local_ip_default[31:8], 8'(host_idx)};
            ip_valid_q   <= 1'b1;
            port_q       <= 16'(ip_q[3:0]) + port_offset;   // one cycle behind ip
            port_valid_q <= 1'b1;
        end
    end

    // mac filter wants the byte order swapped
    always_comb
    begin
        for (int i = 0; i < 6; i++)
            unicast[8*i +: 8] = local_mac[8*(5-i) +: 8];
    end

    assign local_addr = '{ip: ip_q, ip_valid: ip_valid_q, port: port_q,
                          port_valid: port_valid_q, unicast: unicast};

endmodule

`default_nettype wire

// File: verilog/reset_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module reset_sequencer (
    input  logic temac_clk,
    input  logic key1,
    output logic stack_reset,
    output logic phy_reset_n
);
    import udp_ctrl_pkg::*;

    logic [7:0] phy_cnt;    // counts up from key release
    logic [7:0] soft_cnt;   // counts down to stack release

    // --------------------------------------------------
    // phy release
    // --------------------------------------------------
    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
        begin
            phy_cnt <= '0;
        end
        else if (phy_cnt != 8'hff)
        begin
            phy_cnt <= phy_cnt + 8'd1;   // saturate at 255
        end
    end

    assign phy_reset_n = phy_cnt[phy_release_bit];

    // --------------------------------------------------
    // soft stack reset
    // --------------------------------------------------
    always_ff @(posedge temac_clk or negedge key1)
    begin
        if (!key1)
        begin
            soft_cnt <= soft_reset_cycles;
        end
        else if (soft_cnt != 8'd0)
        begin
            soft_cnt <= soft_cnt - 8'd1;
        end
    end

    // count is loaded while key1 is low, so this also covers the key itself
    assign stack_reset = (soft_cnt != 8'd0);

endmodule

`default_nettype wire

// File: verilog/udp_ctrl_pkg.sv
`default_nettype none

package udp_ctrl_pkg;

    // --------------------------------------------------
    // widths and counts
    // --------------------------------------------------
    localparam int data_w      = 32;   // wishbone data
    localparam int adr_w       = 4;    // wishbone word address
    localparam int num_strobes = 6;    // monitored valid strobes

    // --------------------------------------------------
    // address defaults
    // --------------------------------------------------
    localparam logic [31:0] local_ip_default   = 32'hc0a8_f002;
    localparam logic [15:0] local_port_default = 16'h0002;
    localparam logic [47:0] local_mac          = 48'h0123_4567_89ac;
    localparam logic [15:0] port_offset        = 16'd3;   // added to low ip nibble
    localparam int unsigned host_last          = 15;
    localparam int          host_w             = $clog2(host_last + 1);

    // --------------------------------------------------
    // intervals
    // --------------------------------------------------
    localparam int unsigned addr_interval_cycles = 200;   // step every 201 cycles
    localparam int          addr_cnt_w           = $clog2(addr_interval_cycles + 1);
    localparam logic [7:0]  soft_reset_cycles    = 8'd255;
    localparam int          phy_release_bit      = 7;

    // word addresses of the debug register block
    typedef enum logic [adr_w-1:0] {
        reg_app_rx     = 4'd0,
        reg_app_tx     = 4'd1,
        reg_fifo_rx    = 4'd2,
        reg_fifo_tx    = 4'd3,
        reg_mac_rx     = 4'd4,
        reg_mac_tx     = 4'd5,
        reg_local_ip   = 4'd6,
        reg_local_port = 4'd7,   // port, port_valid, ip_valid
        reg_unicast_lo = 4'd8,
        reg_unicast_hi = 4'd9
    } wb_reg_e;

    typedef struct packed {
        logic app_rx;
        logic app_tx;
        logic fifo_rx;   // active low at the pins
        logic fifo_tx;   // active low at the pins
        logic mac_rx;
        logic mac_tx;
    } frame_strobes_t;

    typedef struct packed {
        logic [data_w-1:0] app_rx;
        logic [data_w-1:0] app_tx;
        logic [data_w-1:0] fifo_rx;
        logic [data_w-1:0] fifo_tx;
        logic [data_w-1:0] mac_rx;
        logic [data_w-1:0] mac_tx;
    } frame_counts_t;

    typedef struct packed {
        logic [31:0] ip;
        logic        ip_valid;
        logic [15:0] port;
        logic        port_valid;
        logic [47:0] unicast;
    } local_addr_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [adr_w-1:0]  adr;
        logic [data_w-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [data_w-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// File: verilog/udp_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module udp_ctrl_top (
    input  logic                         temac_clk,
    input  logic                         key1,
    input  udp_ctrl_pkg::frame_strobes_t strobes,      // fifo fields active low
    input  udp_ctrl_pkg::wb_req_t        wb_i,
    output udp_ctrl_pkg::wb_rsp_t        wb_o,
    output logic                         stack_reset,
    output logic                         phy_reset_n,
    output udp_ctrl_pkg::local_addr_t    local_addr     // to the protocol stack
);
    import udp_ctrl_pkg::*;

    frame_counts_t  counts;
    frame_strobes_t clear;     // one-hot counter clear

    // --------------------------------------------------
    // reset and addressing
    // --------------------------------------------------
    reset_sequencer u_reset_seq (
        .temac_clk   (temac_clk  ),
        .key1        (key1       ),
        .stack_reset (stack_reset),
        .phy_reset_n (phy_reset_n)
    );

    local_address_ctrl u_local_addr (
        .temac_clk   (temac_clk  ),
        .key1        (key1       ),
        .stack_reset (stack_reset),
        .local_addr  (local_addr )
    );

    // --------------------------------------------------
    // debug monitor
    // --------------------------------------------------
    frame_counter_bank u_frame_cnt (
        .temac_clk (temac_clk),
        .key1      (key1     ),
        .strobes   (strobes  ),
        .clear     (clear    ),
        .counts    (counts   )
    );

    debug_wb_regs u_wb_regs (
        .temac_clk  (temac_clk ),
        .key1       (key1      ),
        .wb_i       (wb_i      ),
        .wb_o       (wb_o      ),
        .counts     (counts    ),
        .local_addr (local_addr),
        .clear      (clear     )
    );

endmodule

`default_nettype wire
